/* rtl/soc_pkg.sv */
/*
  SoC bus fabric package
  Bus widths, target address map and SRAM pin widths shared by the
  decoder, the targets and the testbench
*/
package soc_pkg;

  // Master bus
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;

  // Boot ROM, end is exclusive
  localparam logic [ADDR_W-1:0] ROM_BASE = 32'h0000_0200;
  localparam logic [ADDR_W-1:0] ROM_END  = 32'h0002_0000;

  // On-chip RAM
  localparam logic [ADDR_W-1:0] RAM_BASE = 32'h0002_0000;
  localparam logic [ADDR_W-1:0] RAM_SIZE = 32'h0000_8000;

  // External asynchronous SRAM
  localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h0003_0000;
  localparam logic [ADDR_W-1:0] SRAM_SIZE = 32'h0040_0000;

  // LED port, end is exclusive
  localparam logic [ADDR_W-1:0] LED_BASE = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] LED_END  = 32'h2000_0000;

  // Upper half of every ROM word
  localparam logic [15:0] ROM_TAG = 16'hB007;

  localparam int LED_W = 10;

  // SRAM halfword address and data pins
  localparam int SRAM_AW = 18;
  localparam int SRAM_DW = 16;

endpackage

/* rtl/soc_bus_decode.sv */
/*
  Bus address decoder
  Selects one of the four targets from the request address, forms the
  offset from its base and returns that target's read data and ready
*/
module soc_bus_decode (
  input  logic                      i_request,
  input  logic                      i_rw,
  input  logic [soc_pkg::ADDR_W-1:0] i_address,
  input  logic [soc_pkg::DATA_W-1:0] i_wdata,
  output logic                      o_rom_sel,
  output logic                      o_ram_sel,
  output logic                      o_sram_sel,
  output logic                      o_led_sel,
  output logic [soc_pkg::ADDR_W-1:0] o_offset,
  output logic                      o_rw,
  output logic [soc_pkg::DATA_W-1:0] o_wdata,
  input  logic [soc_pkg::DATA_W-1:0] i_rom_rdata,
  input  logic [soc_pkg::DATA_W-1:0] i_ram_rdata,
  input  logic [soc_pkg::DATA_W-1:0] i_sram_rdata,
  input  logic [soc_pkg::DATA_W-1:0] i_led_rdata,
  input  logic                      i_sram_ready,
  output logic [soc_pkg::DATA_W-1:0] o_rdata,
  output logic                      o_ready
);
  import soc_pkg::*;

  logic rom_hit;
  logic ram_hit;
  logic sram_hit;
  logic led_hit;

  // Regions are disjoint, so at most one hit
  assign rom_hit  = (i_address >= ROM_BASE) && (i_address < ROM_END);
  assign ram_hit  = (i_address >= RAM_BASE) && (i_address < RAM_BASE + RAM_SIZE);
  assign sram_hit = (i_address >= SRAM_BASE) && (i_address < SRAM_BASE + SRAM_SIZE);
  assign led_hit  = (i_address >= LED_BASE) && (i_address < LED_END);

  assign o_rom_sel  = i_request && rom_hit;
  assign o_ram_sel  = i_request && ram_hit;
  assign o_sram_sel = i_request && sram_hit;
  assign o_led_sel  = i_request && led_hit;

  // Byte offset from the base of the matching region
  always_comb begin
    if (rom_hit) begin
      o_offset = i_address - ROM_BASE;
    end else if (ram_hit) begin
      o_offset = i_address - RAM_BASE;
    end else if (sram_hit) begin
      o_offset = i_address - SRAM_BASE;
    end else if (led_hit) begin
      o_offset = i_address - LED_BASE;
    end else begin
      o_offset = i_address;
    end
  end

  assign o_rw    = i_rw;
  assign o_wdata = i_wdata;

  // Unmapped reads return zero
  always_comb begin
    if (o_rom_sel) begin
      o_rdata = i_rom_rdata;
    end else if (o_ram_sel) begin
      o_rdata = i_ram_rdata;
    end else if (o_sram_sel) begin
      o_rdata = i_sram_rdata;
    end else if (o_led_sel) begin
      o_rdata = i_led_rdata;
    end else begin
      o_rdata = '0;
    end
  end

  // Only the SRAM can stall the master
  assign o_ready = o_sram_sel ? i_sram_ready : 1'b1;

endmodule

/* rtl/boot_rom.sv */
/*
  Boot ROM
  Word table over the ROM region, each word holding the ROM tag above
  its own word index, read combinationally
*/
module boot_rom (
  input  logic                      i_sel,
  input  logic [soc_pkg::ADDR_W-1:0] i_offset,
  output logic [soc_pkg::DATA_W-1:0] o_rdata
);
  import soc_pkg::*;

  localparam int ROM_WORDS = int'((ROM_END - ROM_BASE) >> 2);
  localparam int IDX_W     = $clog2(ROM_WORDS);

  logic [DATA_W-1:0] rom [ROM_WORDS];
  logic [IDX_W-1:0]  word_idx;

  // Fixed content, tag in the upper half and index in the lower half
  initial begin
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom[i] = {ROM_TAG, 16'(i)};
    end
  end

  // Byte offset to word index
  assign word_idx = i_offset[IDX_W+1:2];

  assign o_rdata = i_sel ? rom[word_idx] : '0;

endmodule

/* rtl/block_ram.sv */
/*
  On-chip block RAM
  Word array with a clocked write and a combinational read, the word
  index wrapping at the array depth
*/
module block_ram #(
  parameter int RAM_WORDS = 1024
) (
  input  logic                      CLOCK_50_B5B,
  input  logic                      i_sel,
  input  logic                      i_rw,
  input  logic [soc_pkg::ADDR_W-1:0] i_offset,
  input  logic [soc_pkg::DATA_W-1:0] i_wdata,
  output logic [soc_pkg::DATA_W-1:0] o_rdata
);
  import soc_pkg::*;

  localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

  logic [DATA_W-1:0] mem [RAM_WORDS];
  logic [IDX_W-1:0]  word_idx;

  // Region is larger than the array, so addresses alias
  assign word_idx = IDX_W'((i_offset >> 2) % RAM_WORDS);

  always_ff @(posedge CLOCK_50_B5B) begin
    if (i_sel && i_rw) begin
      mem[word_idx] <= i_wdata;
    end
  end

  assign o_rdata = mem[word_idx];

endmodule

/* rtl/sram_interface.sv */
/*
  External SRAM controller
  Splits each 32-bit bus access into a low and a high 16-bit cycle on
  the asynchronous SRAM, each stretched by a number of wait states
*/
module sram_interface #(
  parameter int WAIT_STATES = 1
) (
  input  logic                       CLOCK_50_B5B,
  input  logic                       i_rst_n,
  input  logic                       i_sel,
  input  logic                       i_rw,
  input  logic [soc_pkg::ADDR_W-1:0]  i_offset,
  input  logic [soc_pkg::DATA_W-1:0]  i_wdata,
  output logic [soc_pkg::DATA_W-1:0]  o_rdata,
  output logic                       o_ready,
  output logic [soc_pkg::SRAM_AW-1:0] o_sram_a,
  output logic [soc_pkg::SRAM_DW-1:0] o_sram_d,
  output logic                       o_sram_d_oe,
  input  logic [soc_pkg::SRAM_DW-1:0] i_sram_d,
  output logic                       o_sram_ce_n,
  output logic                       o_sram_oe_n,
  output logic                       o_sram_we_n,
  output logic                       o_sram_lb_n,
  output logic                       o_sram_ub_n
);
  import soc_pkg::*;

  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(WAIT_STATES);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOW,
    ST_HIGH,
    ST_DONE
  } state_t;

  state_t            state_q;
  logic [CNT_W-1:0]  wait_q;
  logic [DATA_W-1:0] rdata_q;
  logic              in_half;
  logic              half_hi;
  logic              half_last;

  assign in_half   = (state_q == ST_LOW) || (state_q == ST_HIGH);
  // Address stays on the odd halfword through the done cycle
  assign half_hi   = (state_q == ST_HIGH) || (state_q == ST_DONE);
  assign half_last = (wait_q == CNT_LAST);

  always_ff @(posedge CLOCK_50_B5B) begin
    if (!i_rst_n) begin
      state_q <= ST_IDLE;
      wait_q  <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          wait_q <= '0;
          if (i_sel) begin
            state_q <= ST_LOW;
          end
        end
        ST_LOW: begin
          if (half_last) begin
            state_q <= ST_HIGH;
            wait_q  <= '0;
          end else begin
            wait_q <= wait_q + 1'b1;
          end
        end
        ST_HIGH: begin
          if (half_last) begin
            state_q <= ST_DONE;
            wait_q  <= '0;
          end else begin
            wait_q <= wait_q + 1'b1;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Sample read data at the last cycle of each half
  always_ff @(posedge CLOCK_50_B5B) begin
    if (!i_rw && half_last && state_q == ST_LOW) begin
      rdata_q[SRAM_DW-1:0] <= i_sram_d;
    end
    if (!i_rw && half_last && state_q == ST_HIGH) begin
      rdata_q[DATA_W-1:SRAM_DW] <= i_sram_d;
    end
  end

  assign o_rdata = rdata_q;
  assign o_ready = (state_q == ST_DONE);

  // Low word at the even halfword
  assign o_sram_a = {i_offset[SRAM_AW:2], half_hi};
  assign o_sram_d = half_hi ? i_wdata[DATA_W-1:SRAM_DW] : i_wdata[SRAM_DW-1:0];

  assign o_sram_d_oe = in_half && i_rw;
  assign o_sram_ce_n = !in_half;
  assign o_sram_oe_n = !(in_half && !i_rw);

  // Strobe held off in the first cycle so address and data settle first
  assign o_sram_we_n = !(in_half && i_rw && (WAIT_STATES == 0 || wait_q != '0));

  // Full halfword on every access
  assign o_sram_lb_n = 1'b0;
  assign o_sram_ub_n = 1'b0;

endmodule

/* rtl/led_port.sv */
/*
  Memory-mapped LED port
  LED register with load, set, clear and toggle offsets and read-back
*/
module led_port (
  input  logic                      CLOCK_50_B5B,
  input  logic                      i_rst_n,
  input  logic                      i_sel,
  input  logic                      i_rw,
  input  logic [soc_pkg::ADDR_W-1:0] i_offset,
  input  logic [soc_pkg::DATA_W-1:0] i_wdata,
  output logic [soc_pkg::DATA_W-1:0] o_rdata,
  output logic [soc_pkg::LED_W-1:0]  o_leds
);
  import soc_pkg::*;

  logic [LED_W-1:0] wbits;

  assign wbits = i_wdata[LED_W-1:0];

  always_ff @(posedge CLOCK_50_B5B) begin
    if (!i_rst_n) begin
      o_leds <= '0;
    end else if (i_sel && i_rw) begin
      // Other offsets are ignored on write
      case (i_offset)
        'h0:     o_leds <= wbits;
        'h4:     o_leds <= o_leds | wbits;
        'h8:     o_leds <= o_leds & ~wbits;
        'hC:     o_leds <= o_leds ^ wbits;
        default: o_leds <= o_leds;
      endcase
    end
  end

  // Same value at every offset
  assign o_rdata = DATA_W'(o_leds);

endmodule

/* rtl/soc_top.sv */
/*
  SoC bus fabric top level
  Master bus ports feed the address decoder, which fans out to the boot
  ROM, on-chip RAM, external SRAM controller and LED port
*/
module soc_top #(
  parameter int RAM_WORDS   = 1024,
  parameter int WAIT_STATES = 1
) (
  input  logic                       CLOCK_50_B5B,
  input  logic                       i_rst_n,
  input  logic                       i_request,
  input  logic                       i_rw,
  input  logic [soc_pkg::ADDR_W-1:0]  i_address,
  input  logic [soc_pkg::DATA_W-1:0]  i_wdata,
  output logic [soc_pkg::DATA_W-1:0]  o_rdata,
  output logic                       o_ready,
  output logic [soc_pkg::LED_W-1:0]   o_leds,
  output logic [soc_pkg::SRAM_AW-1:0] o_sram_a,
  output logic [soc_pkg::SRAM_DW-1:0] o_sram_d,
  output logic                       o_sram_d_oe,
  input  logic [soc_pkg::SRAM_DW-1:0] i_sram_d,
  output logic                       o_sram_ce_n,
  output logic                       o_sram_oe_n,
  output logic                       o_sram_we_n,
  output logic                       o_sram_lb_n,
  output logic                       o_sram_ub_n
);
  import soc_pkg::*;

  logic              rom_sel;
  logic              ram_sel;
  logic              sram_sel;
  logic              led_sel;
  logic [ADDR_W-1:0] offset;
  logic              bus_rw;
  logic [DATA_W-1:0] bus_wdata;
  logic [DATA_W-1:0] rom_rdata;
  logic [DATA_W-1:0] ram_rdata;
  logic [DATA_W-1:0] sram_rdata;
  logic [DATA_W-1:0] led_rdata;
  logic              sram_ready;

  soc_bus_decode u_decode (
    .i_request    (i_request),
    .i_rw         (i_rw),
    .i_address    (i_address),
    .i_wdata      (i_wdata),
    .o_rom_sel    (rom_sel),
    .o_ram_sel    (ram_sel),
    .o_sram_sel   (sram_sel),
    .o_led_sel    (led_sel),
    .o_offset     (offset),
    .o_rw         (bus_rw),
    .o_wdata      (bus_wdata),
    .i_rom_rdata  (rom_rdata),
    .i_ram_rdata  (ram_rdata),
    .i_sram_rdata (sram_rdata),
    .i_led_rdata  (led_rdata),
    .i_sram_ready (sram_ready),
    .o_rdata      (o_rdata),
    .o_ready      (o_ready)
  );

  boot_rom u_rom (
    .i_sel    (rom_sel),
    .i_offset (offset),
    .o_rdata  (rom_rdata)
  );

  block_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) u_ram (
    .CLOCK_50_B5B (CLOCK_50_B5B),
    .i_sel        (ram_sel),
    .i_rw         (bus_rw),
    .i_offset     (offset),
    .i_wdata      (bus_wdata),
    .o_rdata      (ram_rdata)
  );

  sram_interface #(
    .WAIT_STATES (WAIT_STATES)
  ) u_sram (
    .CLOCK_50_B5B (CLOCK_50_B5B),
    .i_rst_n      (i_rst_n),
    .i_sel        (sram_sel),
    .i_rw         (bus_rw),
    .i_offset     (offset),
    .i_wdata      (bus_wdata),
    .o_rdata      (sram_rdata),
    .o_ready      (sram_ready),
    .o_sram_a     (o_sram_a),
    .o_sram_d     (o_sram_d),
    .o_sram_d_oe  (o_sram_d_oe),
    .i_sram_d     (i_sram_d),
    .o_sram_ce_n  (o_sram_ce_n),
    .o_sram_oe_n  (o_sram_oe_n),
    .o_sram_we_n  (o_sram_we_n),
    .o_sram_lb_n  (o_sram_lb_n),
    .o_sram_ub_n  (o_sram_ub_n)
  );

  led_port u_led (
    .CLOCK_50_B5B (CLOCK_50_B5B),
    .i_rst_n      (i_rst_n),
    .i_sel        (led_sel),
    .i_rw         (bus_rw),
    .i_offset     (offset),
    .i_wdata      (bus_wdata),
    .o_rdata      (led_rdata),
    .o_leds       (o_leds)
  );

endmodule

/* bench/sram_model.sv */
/*
  Behavioral asynchronous SRAM
  16-bit wide array with byte lanes, combinational read and a write
  committed on the rising edge of the write strobe
*/
module sram_model (
  input  logic [soc_pkg::SRAM_AW-1:0] i_a,
  input  logic [soc_pkg::SRAM_DW-1:0] i_d,
  output logic [soc_pkg::SRAM_DW-1:0] o_d,
  input  logic                       i_ce_n,
  input  logic                       i_oe_n,
  input  logic                       i_we_n,
  input  logic                       i_lb_n,
  input  logic                       i_ub_n
);
  import soc_pkg::*;

  localparam int DEPTH = 1 << SRAM_AW;

  logic [SRAM_DW-1:0] mem [DEPTH];
  logic [SRAM_AW-1:0] a_dly;
  logic [SRAM_DW-1:0] d_dly;
  logic               ce_n_dly;
  logic               lb_n_dly;
  logic               ub_n_dly;

  // Pins as seen just before the strobe edge, a small hold time
  assign #1 a_dly    = i_a;
  assign #1 d_dly    = i_d;
  assign #1 ce_n_dly = i_ce_n;
  assign #1 lb_n_dly = i_lb_n;
  assign #1 ub_n_dly = i_ub_n;

  always @(posedge i_we_n) begin
    if (!ce_n_dly) begin
      if (!lb_n_dly) begin
        mem[a_dly][7:0] <= d_dly[7:0];
      end
      if (!ub_n_dly) begin
        mem[a_dly][15:8] <= d_dly[15:8];
      end
    end
  end

  // Bus floats unless chip and output enables are both active
  assign o_d = (!i_ce_n && !i_oe_n) ? mem[i_a] : 'z;

endmodule

/* bench/soc_props.sv */
/*
  Bus and SRAM pin properties
  Bound into the fabric top level to watch the strobes and the ready
  level of the single-cycle targets
*/
module soc_props (
  input logic                       i_clk,
  input logic                       i_rst_n,
  input logic                       i_request,
  input logic [soc_pkg::ADDR_W-1:0] i_address,
  input logic                       i_ready,
  input logic                       i_sram_we_n,
  input logic                       i_sram_oe_n,
  input logic                       i_sram_d_oe
);
  import soc_pkg::*;

  logic        fast_hit;
  int unsigned fail_count = 0;

  // ROM or on-chip RAM, both answer in the request cycle
  assign fast_hit = ((i_address >= ROM_BASE) && (i_address < ROM_END)) ||
                    ((i_address >= RAM_BASE) && (i_address < RAM_BASE + RAM_SIZE));

  a_strobes: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(!i_sram_we_n && !i_sram_oe_n))
    else begin
      fail_count++;
      $error("SRAM write and output enables active together");
    end

  a_bus_fight: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_sram_d_oe && !i_sram_oe_n))
    else begin
      fail_count++;
      $error("SRAM data driven while the SRAM drives its outputs");
    end

  a_fast_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_request && fast_hit) |-> i_ready)
    else begin
      fail_count++;
      $error("Ready low on a ROM or RAM request at %h", i_address);
    end

endmodule

bind soc_top soc_props u_props (
  .i_clk       (CLOCK_50_B5B),
  .i_rst_n     (i_rst_n),
  .i_request   (i_request),
  .i_address   (i_address),
  .i_ready     (o_ready),
  .i_sram_we_n (o_sram_we_n),
  .i_sram_oe_n (o_sram_oe_n),
  .i_sram_d_oe (o_sram_d_oe)
);

/* bench/tb_soc.sv */
/*
  SoC bus fabric testbench
  Plays the bus master from a stimulus table against all four targets,
  with a behavioral SRAM on the external pins
*/
module tb_soc;
  import soc_pkg::*;

  localparam int RAM_WORDS     = 1024;
  localparam int WAIT_STATES   = 1;
  localparam int READY_TIMEOUT = 50;
  localparam bit RD = 1'b0;
  localparam bit WR = 1'b1;
  localparam int R_NONE = 0;
  localparam int R_ROM  = 1;
  localparam int R_RAM  = 2;
  localparam int R_SRAM = 3;
  localparam int R_LED  = 4;

  // Each row expects read data or the LED value after a write
  typedef struct packed {
    bit          rw;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp;
  } row_t;

  logic                CLOCK_50_B5B;
  logic                i_rst_n;
  logic                i_request;
  logic                i_rw;
  logic [ADDR_W-1:0]   i_address;
  logic [DATA_W-1:0]   i_wdata;
  logic [DATA_W-1:0]   o_rdata;
  logic                o_ready;
  logic [LED_W-1:0]    o_leds;
  logic [SRAM_AW-1:0]  o_sram_a;
  logic [SRAM_DW-1:0]  o_sram_d;
  logic                o_sram_d_oe;
  logic [SRAM_DW-1:0]  i_sram_d;
  logic                o_sram_ce_n;
  logic                o_sram_oe_n;
  logic                o_sram_we_n;
  logic                o_sram_lb_n;
  logic                o_sram_ub_n;

  row_t        rows[$];
  logic [31:0] sram_keep;
  int          errors;
  int          checks;

  soc_top #(
    .RAM_WORDS   (RAM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) uut (
    .CLOCK_50_B5B (CLOCK_50_B5B),
    .i_rst_n      (i_rst_n),
    .i_request    (i_request),
    .i_rw         (i_rw),
    .i_address    (i_address),
    .i_wdata      (i_wdata),
    .o_rdata      (o_rdata),
    .o_ready      (o_ready),
    .o_leds       (o_leds),
    .o_sram_a     (o_sram_a),
    .o_sram_d     (o_sram_d),
    .o_sram_d_oe  (o_sram_d_oe),
    .i_sram_d     (i_sram_d),
    .o_sram_ce_n  (o_sram_ce_n),
    .o_sram_oe_n  (o_sram_oe_n),
    .o_sram_we_n  (o_sram_we_n),
    .o_sram_lb_n  (o_sram_lb_n),
    .o_sram_ub_n  (o_sram_ub_n)
  );

  // Pad drives the SRAM data pins only while the output enable is high
  sram_model u_sram_model (
    .i_a    (o_sram_a),
    .i_d    (o_sram_d_oe ? o_sram_d : 'z),
    .o_d    (i_sram_d),
    .i_ce_n (o_sram_ce_n),
    .i_oe_n (o_sram_oe_n),
    .i_we_n (o_sram_we_n),
    .i_lb_n (o_sram_lb_n),
    .i_ub_n (o_sram_ub_n)
  );

  always #4 CLOCK_50_B5B = ~CLOCK_50_B5B;

  function automatic int region_of(input logic [31:0] a);
    if (a >= ROM_BASE && a < ROM_END) return R_ROM;
    if (a >= RAM_BASE && a < RAM_BASE + RAM_SIZE) return R_RAM;
    if (a >= SRAM_BASE && a < SRAM_BASE + SRAM_SIZE) return R_SRAM;
    if (a >= LED_BASE && a < LED_END) return R_LED;
    return R_NONE;
  endfunction

  // Tag above the word index within the ROM region
  function automatic logic [31:0] rom_word(input logic [31:0] a);
    return {ROM_TAG, 16'((a - ROM_BASE) >> 2)};
  endfunction

  task automatic add_row(input bit rw, input logic [31:0] a, input logic [31:0] w,
                         input logic [31:0] e);
    rows.push_back('{rw, a, w, e});
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic build_table();
    logic [31:0]      d0;
    logic [31:0]      d1;
    logic [31:0]      d2;
    logic [31:0]      s0;
    logic [31:0]      s2;
    logic [31:0]      w;
    logic [LED_W-1:0] leds;
    d0 = $urandom;
    d1 = $urandom;
    d2 = $urandom;
    s0 = $urandom;
    sram_keep = $urandom;
    s2 = $urandom;
    add_row(RD, ROM_BASE, '0, rom_word(ROM_BASE));
    add_row(RD, ROM_BASE + 32'h4, '0, rom_word(ROM_BASE + 32'h4));
    add_row(RD, ROM_BASE + 32'h1234, '0, rom_word(ROM_BASE + 32'h1234));
    add_row(RD, ROM_END - 32'h4, '0, rom_word(ROM_END - 32'h4));
    add_row(WR, RAM_BASE, d0, '0);
    add_row(WR, RAM_BASE + 32'h10, d1, '0);
    add_row(WR, RAM_BASE + RAM_SIZE - 32'h4, d2, '0);
    add_row(RD, RAM_BASE, '0, d0);
    add_row(RD, RAM_BASE + 32'h10, '0, d1);
    // One array depth further on aliases to the same word
    add_row(RD, RAM_BASE + 32'(4 * (RAM_WORDS + 4)), '0, d1);
    add_row(RD, RAM_BASE + RAM_SIZE - 32'h4, '0, d2);
    add_row(WR, SRAM_BASE, s0, '0);
    add_row(WR, SRAM_BASE + 32'h100, sram_keep, '0);
    add_row(WR, SRAM_BASE + 32'h7FFFC, s2, '0);
    add_row(RD, SRAM_BASE, '0, s0);
    add_row(RD, SRAM_BASE + 32'h100, '0, sram_keep);
    add_row(RD, SRAM_BASE + 32'h7FFFC, '0, s2);
    w = 32'hABCD_E2A5;
    leds = w[LED_W-1:0];
    add_row(WR, LED_BASE, w, 32'(leds));
    w = 32'h0000_000F;
    leds = leds | w[LED_W-1:0];
    add_row(WR, LED_BASE + 32'h4, w, 32'(leds));
    w = 32'h0000_00A0;
    leds = leds & ~w[LED_W-1:0];
    add_row(WR, LED_BASE + 32'h8, w, 32'(leds));
    w = 32'h0000_03FF;
    leds = leds ^ w[LED_W-1:0];
    add_row(WR, LED_BASE + 32'hC, w, 32'(leds));
    add_row(RD, LED_BASE + 32'h20, '0, 32'(leds));
    add_row(RD, 32'h2000_0000, '0, '0);
    add_row(RD, 32'h0000_0100, '0, '0);
    add_row(WR, 32'h2000_0000, $urandom, '0);
    // Nothing moved after the unmapped write
    add_row(RD, RAM_BASE, '0, d0);
    add_row(RD, SRAM_BASE, '0, s0);
    add_row(RD, LED_BASE, '0, 32'(leds));
  endtask

  task automatic run_transfer(input bit rw, input logic [31:0] a, input logic [31:0] w,
                              output logic [31:0] rdata, output int waits, output bit ok);
    @(posedge CLOCK_50_B5B);
    i_request <= 1'b1;
    i_rw      <= rw;
    i_address <= a;
    i_wdata   <= w;
    waits = 0;
    @(negedge CLOCK_50_B5B);
    while (!o_ready && waits < READY_TIMEOUT) begin
      waits++;
      @(negedge CLOCK_50_B5B);
    end
    ok = o_ready;
    rdata = o_rdata;
    if (!ok) begin
      errors++;
      $display("Timeout: no ready within %0d cycles for address %h", READY_TIMEOUT, a);
    end
    // Transfer completes on this edge
    @(posedge CLOCK_50_B5B);
    i_request <= 1'b0;
  endtask

  task automatic check_row(input row_t r, input logic [31:0] rdata, input int waits);
    int               region;
    logic [SRAM_AW-1:0] ha;
    region = region_of(r.addr);
    ha = SRAM_AW'((r.addr - SRAM_BASE) >> 1);
    if (region == R_SRAM && waits == 0) begin
      errors++;
      $display("SRAM access at %h finished without any wait cycle", r.addr);
    end else if (region != R_SRAM && waits != 0) begin
      errors++;
      $display("Ready came %0d cycles late for address %h", waits, r.addr);
    end
    if (r.rw == RD) begin
      check_word("o_rdata", rdata, r.exp);
      if (region == R_LED) begin
        check_word("o_leds", 32'(o_leds), rdata);
      end
    end else if (region == R_LED) begin
      check_word("o_leds", 32'(o_leds), r.exp);
    end else if (region == R_SRAM) begin
      check_word("sram low half", 32'(u_sram_model.mem[ha]), 32'(r.wdata[15:0]));
      check_word("sram high half", 32'(u_sram_model.mem[ha + 1'b1]), 32'(r.wdata[31:16]));
    end
  endtask

  task automatic reset_mid_run();
    logic [31:0] rdata;
    int          waits;
    bit          ok;
    @(posedge CLOCK_50_B5B);
    i_request <= 1'b1;
    i_rw      <= WR;
    i_address <= SRAM_BASE + 32'h200;
    i_wdata   <= $urandom;
    // Reset lands while the SRAM write is under way
    repeat (3) @(posedge CLOCK_50_B5B);
    i_rst_n   <= 1'b0;
    i_request <= 1'b0;
    // First reset edge, the write strobe would be low here otherwise
    @(posedge CLOCK_50_B5B);
    @(negedge CLOCK_50_B5B);
    check_word("o_leds", 32'(o_leds), '0);
    check_word("o_sram_ce_n", 32'(o_sram_ce_n), 32'h1);
    check_word("o_sram_oe_n", 32'(o_sram_oe_n), 32'h1);
    check_word("o_sram_we_n", 32'(o_sram_we_n), 32'h1);
    check_word("o_sram_d_oe", 32'(o_sram_d_oe), 32'h0);
    repeat (2) @(posedge CLOCK_50_B5B);
    i_rst_n <= 1'b1;
    run_transfer(RD, SRAM_BASE + 32'h100, '0, rdata, waits, ok);
    if (ok) begin
      check_word("o_rdata", rdata, sram_keep);
    end
  endtask

  initial begin
    logic [31:0] rdata;
    int          waits;
    bit          ok;
    CLOCK_50_B5B = 1'b0;
    i_rst_n      = 1'b0;
    i_request    = 1'b0;
    i_rw         = 1'b0;
    i_address    = '0;
    i_wdata      = '0;
    errors       = 0;
    checks       = 0;
    void'($urandom(77671));
    build_table();
    repeat (3) @(posedge CLOCK_50_B5B);
    i_rst_n <= 1'b1;
    foreach (rows[i]) begin
      run_transfer(rows[i].rw, rows[i].addr, rows[i].wdata, rdata, waits, ok);
      @(negedge CLOCK_50_B5B);
      if (ok) begin
        check_row(rows[i], rdata, waits);
      end
    end
    reset_mid_run();
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, uut.u_props.fail_count);
    if (errors == 0 && uut.u_props.fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* tb.f */
rtl/soc_pkg.sv
rtl/soc_bus_decode.sv
rtl/boot_rom.sv
rtl/block_ram.sv
rtl/sram_interface.sv
rtl/led_port.sv
rtl/soc_top.sv
bench/sram_model.sv
bench/soc_props.sv
bench/tb_soc.sv
